// ==== list.f ====
hw/mmu_pkg.sv
hw/mmu_refill_ctrl.sv
hw/mmu_icache.sv
hw/mmu_dmem.sv
hw/mmu_top.sv
dv/mmu_tb.sv

// ==== Bender.yml ====
package:
  name: mmu

sources:
  - files:
      - hw/mmu_pkg.sv
      - hw/mmu_refill_ctrl.sv
      - hw/mmu_icache.sv
      - hw/mmu_dmem.sv
      - hw/mmu_top.sv
  - target: test
    files:
      - dv/mmu_tb.sv

// ==== dv/mmu_tb.sv ====
// directed testbench for the mmu with host responder model, compare tasks and watchdog
`default_nettype none

module mmu_tb;

    localparam int NUM_LINES = 4;
    localparam int IMEM_WORDS = 1024;
    localparam int DMEM_WORDS = 256;
    localparam int NUM_TESTS = 5;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 200;
    localparam int REFILL_LIMIT = 40;
    localparam int TIMER_CYCLES = 20;
    localparam mmu_pkg::word_t LINE_KEY = 32'h5a3c_0f00;

    logic                clk;
    logic                rst_n;
    mmu_pkg::addr_t      i_i_addr;
    logic                i_i_rd;
    mmu_pkg::word_t      o_i_rd_data;
    logic                o_i_miss;
    logic                o_i_segfault;
    mmu_pkg::addr_t      i_d_addr;
    mmu_pkg::word_t      i_d_wr_data;
    logic                i_d_rd;
    logic                i_d_wr;
    mmu_pkg::word_t      o_d_rd_data;
    logic                o_d_segfault;
    logic                i_running;
    mmu_pkg::host_resp_t i_host_resp;
    mmu_pkg::line_t      i_host_line;
    logic                o_host_rd_req;
    mmu_pkg::addr_t      o_host_rd_addr;
    mmu_pkg::mbox_t      o_mailbox;
    mmu_pkg::word_t      o_cycle_count;
    logic                o_finish;

    int seed = 21;

    mmu_top #(
        .NUM_LINES  (NUM_LINES),
        .IMEM_WORDS (IMEM_WORDS),
        .DMEM_WORDS (DMEM_WORDS)
    ) dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // word k of line base b is b + k, scrambled by a key.
    function automatic mmu_pkg::word_t expected_fetch(mmu_pkg::addr_t a);
        return ((a & ~32'h7) + (a & 32'h7)) ^ LINE_KEY;
    endfunction

    function automatic mmu_pkg::line_t host_line_for(mmu_pkg::addr_t base);
        mmu_pkg::line_t line;
        for (int k = 0; k < mmu_pkg::LINE_WORDS; k++) begin
            line[k] = (base + k) ^ LINE_KEY;
        end
        return line;
    endfunction

    task automatic fail_run(string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(string name, mmu_pkg::word_t got, mmu_pkg::word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_addr(string name, mmu_pkg::addr_t got, mmu_pkg::addr_t exp);
        if (got !== exp) begin
            fail_run($sformatf("error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            fail_run($sformatf("error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_mbox(string name, mmu_pkg::mbox_t got, mmu_pkg::mbox_t exp);
        if (got !== exp) begin
            fail_run($sformatf("error: %s got %h expected %h", name, got, exp));
        end
    endtask

    // answers each request with random delays on both phases.
    initial begin : host_model
        mmu_pkg::addr_t base;
        int unsigned delay;
        i_host_resp = '0;
        i_host_line = '0;
        forever begin
            @(negedge clk);
            if (o_host_rd_req) begin
                base = o_host_rd_addr;
                delay = 1 + ($unsigned($random(seed)) % 4);
                repeat (delay) @(negedge clk);
                i_host_resp.req_taken = 1'b1;
                @(negedge clk);
                i_host_resp.req_taken = 1'b0;
                delay = 1 + ($unsigned($random(seed)) % 4);
                repeat (delay) @(negedge clk);
                i_host_line = host_line_for(base); // held until the next request.
                i_host_resp.data_valid = 1'b1;
                @(negedge clk);
                i_host_resp.data_valid = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        fail_run($sformatf("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES));
    end

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic fetch_refill(mmu_pkg::addr_t a);
        int waited = 0;
        i_i_addr = a;
        i_i_rd = 1'b1;
        @(negedge clk);
        check_bit("o_i_miss", o_i_miss, 1'b1);
        check_bit("o_host_rd_req", o_host_rd_req, 1'b1);
        check_addr("o_host_rd_addr", o_host_rd_addr, a & ~32'h7);
        while (o_i_miss) begin
            @(negedge clk);
            waited++;
            if (waited > REFILL_LIMIT) begin
                fail_run("refill did not finish, miss stayed high");
            end
        end
        check_word("o_i_rd_data", o_i_rd_data, expected_fetch(a));
    endtask

    task automatic fetch_hit(mmu_pkg::addr_t a);
        i_i_addr = a;
        i_i_rd = 1'b1;
        @(negedge clk);
        check_bit("o_i_miss", o_i_miss, 1'b0);
        check_word("o_i_rd_data", o_i_rd_data, expected_fetch(a));
    endtask

    task automatic write_data(mmu_pkg::addr_t a, mmu_pkg::word_t d, logic seg);
        i_d_addr = a;
        i_d_wr_data = d;
        i_d_wr = 1'b1;
        @(negedge clk);
        check_bit("o_d_segfault", o_d_segfault, seg);
        i_d_wr = 1'b0;
    endtask

    task automatic read_check(mmu_pkg::addr_t a, mmu_pkg::word_t exp, logic seg);
        i_d_addr = a;
        i_d_rd = 1'b1;
        @(negedge clk);
        check_bit("o_d_segfault", o_d_segfault, seg);
        check_word("o_d_rd_data", o_d_rd_data, exp);
        i_d_rd = 1'b0;
    endtask

    task automatic test_cold_line();
        fetch_refill(32'h43);
        for (int k = 0; k < mmu_pkg::LINE_WORDS; k++) begin
            fetch_hit(32'h40 + k);
        end
        i_i_rd = 1'b0;
    endtask

    task automatic test_eviction();
        mmu_pkg::addr_t alias_base;
        alias_base = 32'h40 + NUM_LINES * mmu_pkg::LINE_WORDS; // same index, new tag.
        fetch_refill(alias_base + 5);
        fetch_hit(alias_base);
        fetch_refill(32'h42);
        i_i_rd = 1'b0;
    endtask

    task automatic test_fetch_segfault();
        i_i_addr = IMEM_WORDS + 5;
        i_i_rd = 1'b1;
        repeat (10) begin
            @(negedge clk);
            check_bit("o_i_segfault", o_i_segfault, 1'b1);
            check_bit("o_i_miss", o_i_miss, 1'b0);
            check_bit("o_host_rd_req", o_host_rd_req, 1'b0);
        end
        i_i_rd = 1'b0;
    endtask

    task automatic test_data_memory();
        mmu_pkg::word_t model [DMEM_WORDS];
        mmu_pkg::addr_t used [$];
        mmu_pkg::addr_t a;
        mmu_pkg::word_t d;
        for (int n = 0; n < 16; n++) begin
            a = mmu_pkg::MBOX_REGS
                + ($unsigned($random(seed)) % (DMEM_WORDS - mmu_pkg::MBOX_REGS));
            d = $random(seed);
            write_data(a, d, 1'b0);
            model[a] = d;
            used.push_back(a);
        end
        foreach (used[n]) begin
            read_check(used[n], model[used[n]], 1'b0);
        end
        write_data(7, 32'h0bad_f00d, 1'b0);
        write_data(DMEM_WORDS + 7, 32'hdead_beef, 1'b1); // aliases word 7 if not dropped.
        read_check(DMEM_WORDS + 7, '0, 1'b1);
        read_check(7, 32'h0bad_f00d, 1'b0);
    endtask

    task automatic test_mailbox_timer();
        mmu_pkg::mbox_t exp_mbox;
        apply_reset();
        i_running = 1'b1;
        for (int r = 0; r < mmu_pkg::MBOX_REGS; r++) begin
            exp_mbox[r] = 32'hc0de_0000 + 32'h11 * r;
            write_data(r, exp_mbox[r], 1'b0);
        end
        check_mbox("o_mailbox", o_mailbox, exp_mbox);
        for (int r = 0; r < mmu_pkg::MBOX_REGS; r++) begin
            read_check(r, exp_mbox[r], 1'b0);
        end
        fetch_refill(32'h18);
        fetch_hit(32'h18); // first hitting edge arms the timer.
        i_i_rd = 1'b0;
        repeat (TIMER_CYCLES) @(negedge clk);
        i_running = 1'b0;
        @(negedge clk);
        check_word("o_cycle_count", o_cycle_count, TIMER_CYCLES);
        check_bit("o_finish", o_finish, 1'b1);
    endtask

    initial begin
        rst_n = 1'b0;
        i_i_addr = '0;
        i_i_rd = 1'b0;
        i_d_addr = '0;
        i_d_wr_data = '0;
        i_d_rd = 1'b0;
        i_d_wr = 1'b0;
        i_running = 1'b0;
        apply_reset();
        test_cold_line();
        test_eviction();
        test_fetch_segfault();
        test_data_memory();
        test_mailbox_timer();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/mmu_top.sv ====
// memory management unit top with instruction cache, data memory and refill controller
`default_nettype none

module mmu_top #(
    parameter int NUM_LINES  = 4,
    parameter int IMEM_WORDS = 1024,
    parameter int DMEM_WORDS = 256
) (
    input  wire                 clk,
    input  wire                 rst_n,

    input  mmu_pkg::addr_t      i_i_addr,
    input  wire                 i_i_rd,
    output mmu_pkg::word_t      o_i_rd_data,
    output logic                o_i_miss,
    output logic                o_i_segfault,

    input  mmu_pkg::addr_t      i_d_addr,
    input  mmu_pkg::word_t      i_d_wr_data,
    input  wire                 i_d_rd,
    input  wire                 i_d_wr,
    output mmu_pkg::word_t      o_d_rd_data,
    output logic                o_d_segfault,

    input  wire                 i_running,
    input  mmu_pkg::host_resp_t i_host_resp,
    input  mmu_pkg::line_t      i_host_line,
    output logic                o_host_rd_req,
    output mmu_pkg::addr_t      o_host_rd_addr,

    output mmu_pkg::mbox_t      o_mailbox,
    output mmu_pkg::word_t      o_cycle_count,
    output logic                o_finish
);

    logic           refill_req;
    mmu_pkg::addr_t miss_line;
    logic           fill;

    mmu_icache #(
        .NUM_LINES  (NUM_LINES),
        .IMEM_WORDS (IMEM_WORDS)
    ) u_icache (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_i_addr     (i_i_addr),
        .i_i_rd       (i_i_rd),
        .o_i_rd_data  (o_i_rd_data),
        .o_i_miss     (o_i_miss),
        .o_i_segfault (o_i_segfault),
        .o_refill_req (refill_req),
        .o_miss_line  (miss_line),
        .i_fill       (fill),
        .i_host_line  (i_host_line)
    );

    mmu_refill_ctrl u_refill_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_refill_req   (refill_req),
        .i_miss_line    (miss_line),
        .i_i_rd         (i_i_rd),
        .i_i_miss       (o_i_miss),
        .i_running      (i_running),
        .i_host_resp    (i_host_resp),
        .o_host_rd_req  (o_host_rd_req),
        .o_host_rd_addr (o_host_rd_addr),
        .o_fill         (fill),
        .o_cycle_count  (o_cycle_count),
        .o_finish       (o_finish)
    );

    mmu_dmem #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_dmem (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_d_addr     (i_d_addr),
        .i_d_wr_data  (i_d_wr_data),
        .i_d_rd       (i_d_rd),
        .i_d_wr       (i_d_wr),
        .o_d_rd_data  (o_d_rd_data),
        .o_d_segfault (o_d_segfault),
        .o_mailbox    (o_mailbox)
    );

endmodule

`default_nettype wire

// ==== hw/mmu_dmem.sv ====
// data memory with address decode, mailbox registers, registered reads, segfault flag
`default_nettype none

module mmu_dmem #(
    parameter int DMEM_WORDS = 256
) (
    input  wire             clk,
    input  wire             rst_n,

    input  mmu_pkg::addr_t  i_d_addr,
    input  mmu_pkg::word_t  i_d_wr_data,
    input  wire             i_d_rd,
    input  wire             i_d_wr,
    output mmu_pkg::word_t  o_d_rd_data,
    output logic            o_d_segfault,

    output mmu_pkg::mbox_t  o_mailbox
);

    localparam int MEM_AW = $clog2(DMEM_WORDS);
    localparam int SEL_BITS = mmu_pkg::MBOX_SEL_BITS;

    mmu_pkg::word_t mem_q [DMEM_WORDS];
    mmu_pkg::mbox_t mbox_q;
    mmu_pkg::word_t rd_data_q;

    logic              is_mbox;
    logic              in_range;
    logic [MEM_AW-1:0] mem_idx;
    logic [SEL_BITS-1:0] mbox_sel;

    assign is_mbox = i_d_addr < mmu_pkg::addr_t'(mmu_pkg::MBOX_REGS);
    assign in_range = i_d_addr < mmu_pkg::addr_t'(DMEM_WORDS);
    assign mem_idx = i_d_addr[MEM_AW-1:0];
    assign mbox_sel = i_d_addr[SEL_BITS-1:0];

    assign o_d_segfault = (i_d_rd | i_d_wr) & ~in_range;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mbox_q <= '0;
        end else if (i_d_wr && is_mbox) begin
            mbox_q[mbox_sel] <= i_d_wr_data;
        end
    end

    // low words of the array shadow the mailbox and stay unused.
    always_ff @(posedge clk) begin
        if (i_d_wr && in_range && !is_mbox) begin
            mem_q[mem_idx] <= i_d_wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (i_d_rd) begin
            if (is_mbox) begin
                rd_data_q <= mbox_q[mbox_sel];
            end else if (in_range) begin
                rd_data_q <= mem_q[mem_idx];
            end else begin
                rd_data_q <= '0; // out of range reads zero.
            end
        end
    end

    assign o_d_rd_data = rd_data_q;
    assign o_mailbox = mbox_q;

endmodule

`default_nettype wire

// ==== hw/mmu_icache.sv ====
// direct-mapped instruction cache with tag check, miss and segfault flags, line fill
`default_nettype none

module mmu_icache #(
    parameter int NUM_LINES  = 4,
    parameter int IMEM_WORDS = 1024
) (
    input  wire             clk,
    input  wire             rst_n,

    input  mmu_pkg::addr_t  i_i_addr,
    input  wire             i_i_rd,
    output mmu_pkg::word_t  o_i_rd_data,
    output logic            o_i_miss,
    output logic            o_i_segfault,

    output logic            o_refill_req,
    output mmu_pkg::addr_t  o_miss_line,
    input  wire             i_fill,
    input  mmu_pkg::line_t  i_host_line
);

    localparam int OFS_BITS = mmu_pkg::LINE_OFS_BITS;
    localparam int IDX_BITS = $clog2(NUM_LINES);
    localparam int TAG_BITS = 32 - OFS_BITS - IDX_BITS;

    typedef logic [IDX_BITS-1:0] idx_t;
    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [OFS_BITS-1:0] ofs_t;

    logic [NUM_LINES-1:0] valid_q;
    tag_t                 tag_q  [NUM_LINES];
    mmu_pkg::line_t       line_q [NUM_LINES];

    idx_t fetch_idx;
    tag_t fetch_tag;
    ofs_t fetch_ofs;
    logic tag_hit;

    assign fetch_ofs = i_i_addr[OFS_BITS-1:0];
    assign fetch_idx = i_i_addr[OFS_BITS +: IDX_BITS];
    assign fetch_tag = i_i_addr[31 -: TAG_BITS];

    assign o_i_segfault = i_i_rd & (i_i_addr >= mmu_pkg::addr_t'(IMEM_WORDS));
    assign tag_hit = valid_q[fetch_idx] & (tag_q[fetch_idx] == fetch_tag);

    // out-of-range fetches never refill.
    assign o_i_miss = i_i_rd & ~o_i_segfault & ~tag_hit;
    assign o_refill_req = o_i_miss;
    assign o_miss_line = {i_i_addr[31:OFS_BITS], {OFS_BITS{1'b0}}};

    assign o_i_rd_data = line_q[fetch_idx][fetch_ofs];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (i_fill) begin
            valid_q[fetch_idx] <= 1'b1;
        end
    end

    // fetch address is held during refill, so it names the line.
    always_ff @(posedge clk) begin
        if (i_fill) begin
            tag_q[fetch_idx] <= fetch_tag;
            line_q[fetch_idx] <= i_host_line;
        end
    end

endmodule

`default_nettype wire

// ==== hw/mmu_refill_ctrl.sv ====
// refill controller running the host read handshake, plus the run timer
`default_nettype none

module mmu_refill_ctrl (
    input  wire                 clk,
    input  wire                 rst_n,

    input  wire                 i_refill_req,
    input  mmu_pkg::addr_t      i_miss_line,

    input  wire                 i_i_rd,
    input  wire                 i_i_miss,
    input  wire                 i_running,

    input  mmu_pkg::host_resp_t i_host_resp,
    output logic                o_host_rd_req,
    output mmu_pkg::addr_t      o_host_rd_addr,
    output logic                o_fill,

    output mmu_pkg::word_t      o_cycle_count,
    output logic                o_finish
);

    mmu_pkg::refill_state_t state_q;
    mmu_pkg::refill_state_t state_d;

    logic counting_q;
    logic fetch_hit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= mmu_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        o_host_rd_req = 1'b0;
        o_host_rd_addr = '0;
        o_fill = 1'b0;
        case (state_q)
            mmu_pkg::IDLE: begin
                if (i_refill_req) begin
                    state_d = mmu_pkg::READ;
                end
            end
            mmu_pkg::READ: begin
                o_host_rd_req = 1'b1;
                o_host_rd_addr = i_miss_line;
                if (i_host_resp.req_taken) begin
                    state_d = mmu_pkg::WAIT;
                end
            end
            mmu_pkg::WAIT: begin
                if (i_host_resp.data_valid) begin
                    state_d = mmu_pkg::DONE;
                end
            end
            mmu_pkg::DONE: begin
                o_fill = 1'b1; // cache takes the line here.
                state_d = mmu_pkg::IDLE;
            end
            default: begin
                state_d = mmu_pkg::IDLE;
            end
        endcase
    end

    assign fetch_hit = i_i_rd & ~i_i_miss;

    // one-shot timer, armed by the first fetch that hits.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            counting_q <= 1'b0;
            o_cycle_count <= '0;
            o_finish <= 1'b0;
        end else if (!counting_q) begin
            if (fetch_hit && !o_finish) begin
                counting_q <= 1'b1;
            end
        end else if (i_running) begin
            o_cycle_count <= o_cycle_count + 1'b1;
        end else begin
            counting_q <= 1'b0; // core stopped.
            o_finish <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/mmu_pkg.sv ====
// shared word, address and line types, host response and mailbox types, refill states
`default_nettype none

package mmu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // one cache line is one host transfer.
    localparam int LINE_WORDS = 8;
    localparam int LINE_OFS_BITS = $clog2(LINE_WORDS);

    typedef word_t [LINE_WORDS-1:0] line_t;

    typedef struct packed {
        logic req_taken;  // host latched the address.
        logic data_valid; // line on the data bus is good.
    } host_resp_t;

    // console registers at the bottom of data space.
    localparam int MBOX_REGS = 4;
    localparam int MBOX_SEL_BITS = $clog2(MBOX_REGS);

    typedef word_t [MBOX_REGS-1:0] mbox_t;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WAIT,
        DONE
    } refill_state_t;

endpackage

`default_nettype wire
